// File: design/wb_master_pkg.sv
`default_nettype none

package wb_master_pkg;

  // user side word width
  localparam int MASTER_W = 32;

  // slave bus data width, MASTER_W must be 1, 2, 4 or 8 times this
  localparam int SLAVE_W = 8;

  // wishbone address width, beat addresses wrap inside this range
  localparam int ADR_W = 8;

  // single accesses needed for one user word
  localparam int BEATS = MASTER_W / SLAVE_W;

  // a one-beat configuration still needs a 1-bit index
  localparam int BEAT_IDX_W = (BEATS > 1) ? $clog2(BEATS) : 1;

  // full user word
  typedef logic [MASTER_W-1:0] master_word_t;

  // one slice as it goes over the bus
  typedef logic [SLAVE_W-1:0] slave_word_t;

  typedef logic [ADR_W-1:0] adr_t;

  // slice number inside a request, 0 is the lowest slice
  typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

endpackage

`default_nettype wire

// File: design/wb_beat_if.sv
`default_nettype none

interface wb_beat_if import wb_master_pkg::*; ();

  logic        beat_valid;  // held until beat_done
  logic        beat_we;
  adr_t        beat_adr;    // base + beat index
  slave_word_t beat_wdat;   // write slice for this beat
  beat_idx_t   beat_idx;
  logic        beat_last;   // final slice of the request
  logic        beat_done;   // ack accepted on the bus
  slave_word_t beat_rdat;   // slave data belonging to that ack

  modport seq (
    output beat_valid,
    output beat_we,
    output beat_adr,
    output beat_wdat,
    output beat_idx,
    output beat_last,
    input  beat_done
  );

  modport port (
    input  beat_valid,
    input  beat_we,
    input  beat_adr,
    input  beat_wdat,
    input  beat_last,
    output beat_done,
    output beat_rdat
  );

  // read side only needs to know where a returned slice belongs
  modport gather (
    input beat_done,
    input beat_we,
    input beat_idx,
    input beat_last,
    input beat_rdat
  );

endinterface

`default_nettype wire

// File: design/wb_beat_seq.sv
`default_nettype none

module wb_beat_seq import wb_master_pkg::*;
(
  input  logic         CLK_I,
  input  logic         RST_I,

  input  logic         req_valid_i,
  input  logic         req_we_i,
  input  adr_t         req_adr_i,
  input  master_word_t req_dat_i,
  output logic         req_ready_o,

  input  logic         rsp_pending_i,
  output logic         xfer_active_o,

  wb_beat_if.seq       beat
);

  typedef enum logic [1:0] {
    IDLE,
    BEAT,
    GAP,
    FINISH
  } seq_state_t;

  seq_state_t   state_q;
  beat_idx_t    idx_q;
  logic         accept;

  // request copy, held for the whole transfer
  logic         hold_we_q;
  adr_t         hold_adr_q;
  master_word_t hold_dat_q;

  // a read response still owned by the user blocks the next request
  assign req_ready_o = (state_q == IDLE) && !rsp_pending_i;
  assign accept      = req_valid_i && req_ready_o;

  // low again once the last beat is acked
  assign xfer_active_o = (state_q == BEAT) || (state_q == GAP);

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      state_q <= IDLE;
      idx_q   <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (accept)
          begin
            idx_q   <= '0;
            state_q <= GAP;  // one cycle to settle the first beat
          end
        end
        GAP:
        begin
          state_q <= BEAT;
        end
        BEAT:
        begin
          if (beat.beat_done)
          begin
            if (beat.beat_last)
            begin
              state_q <= FINISH;
            end
            else
            begin
              idx_q   <= idx_q + 1'b1;
              state_q <= GAP;  // valid drops while the index moves on
            end
          end
        end
        FINISH:
        begin
          state_q <= IDLE;
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK_I)
  begin
    if (accept)
    begin
      hold_we_q  <= req_we_i;
      hold_adr_q <= req_adr_i;
      hold_dat_q <= req_dat_i;
    end
  end

  assign beat.beat_valid = (state_q == BEAT);
  assign beat.beat_we    = hold_we_q;
  assign beat.beat_idx   = idx_q;
  assign beat.beat_last  = (idx_q == beat_idx_t'(BEATS - 1));

  // address wraps at the top of the bus range
  assign beat.beat_adr  = hold_adr_q + adr_t'(idx_q);
  assign beat.beat_wdat = hold_dat_q[idx_q*SLAVE_W +: SLAVE_W];  // lowest slice first

  // the bus port relies on a steady beat until it reports the ack
  beat_hold_a : assert property (
    @(posedge CLK_I) disable iff (RST_I)
    beat.beat_valid && !beat.beat_done |=>
      $stable({beat.beat_we, beat.beat_adr, beat.beat_wdat, beat.beat_idx, beat.beat_last})
  );

endmodule

`default_nettype wire

// File: design/wb_bus_port.sv
`default_nettype none

module wb_bus_port import wb_master_pkg::*;
(
  input  logic        CLK_I,
  input  logic        RST_I,

  input  logic        xfer_active_i,
  wb_beat_if.port     beat,

  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output adr_t        wb_adr_o,
  output slave_word_t wb_dat_o,
  input  slave_word_t wb_dat_i,
  input  logic        wb_ack_i
);

  logic ack_ok;
  logic launch;

  // an ack without strobe is ignored
  assign ack_ok = wb_stb_o && wb_ack_i;
  assign launch = xfer_active_i && beat.beat_valid && !wb_stb_o;

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
    end
    else if (!xfer_active_i)
    begin
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
    end
    else if (ack_ok)
    begin
      wb_stb_o <= 1'b0;
      if (beat.beat_last)
      begin
        wb_cyc_o <= 1'b0;  // cycle ends with the last ack
      end
    end
    else if (launch)
    begin
      wb_cyc_o <= 1'b1;
      wb_stb_o <= 1'b1;
    end
  end

  // beat fields go out together with the strobe
  always_ff @(posedge CLK_I)
  begin
    if (launch)
    begin
      wb_we_o  <= beat.beat_we;
      wb_adr_o <= beat.beat_adr;
      wb_dat_o <= beat.beat_wdat;
    end
  end

  assign beat.beat_done = ack_ok;    // strobe falls next edge, so one cycle wide
  assign beat.beat_rdat = wb_dat_i;  // sampled by the gatherer on that edge

  stb_in_cyc_a : assert property (
    @(posedge CLK_I) disable iff (RST_I)
    wb_stb_o |-> wb_cyc_o
  );

  adr_hold_a : assert property (
    @(posedge CLK_I) disable iff (RST_I)
    wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o)
  );

endmodule

`default_nettype wire

// File: design/wb_read_gather.sv
`default_nettype none

module wb_read_gather import wb_master_pkg::*;
(
  input  logic         CLK_I,
  input  logic         RST_I,

  wb_beat_if.gather    beat,

  input  logic         rsp_ready_i,
  output logic         rsp_valid_o,
  output master_word_t rsp_dat_o,
  output logic         rsp_pending_o
);

  master_word_t asm_q;
  master_word_t asm_next;
  master_word_t rsp_dat_q;
  logic         rsp_valid_q;
  logic         rd_done;

  assign rd_done = beat.beat_done && !beat.beat_we;

  // merge the returned slice into the partial word
  always_comb
  begin
    asm_next = asm_q;
    asm_next[beat.beat_idx*SLAVE_W +: SLAVE_W] = beat.beat_rdat;
  end

  always_ff @(posedge CLK_I)
  begin
    if (rd_done)
    begin
      asm_q <= asm_next;
      if (beat.beat_last)
      begin
        rsp_dat_q <= asm_next;  // complete word, held until taken
      end
    end
  end

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      rsp_valid_q <= 1'b0;
    end
    else if (rd_done && beat.beat_last)
    begin
      rsp_valid_q <= 1'b1;
    end
    else if (rsp_ready_i)
    begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_valid_o   = rsp_valid_q;
  assign rsp_dat_o     = rsp_dat_q;
  assign rsp_pending_o = rsp_valid_q;  // sequencer holds off new requests

  // the sequencer must not start a read over an unclaimed response
  no_read_over_rsp_a : assert property (
    @(posedge CLK_I) disable iff (RST_I)
    rd_done |-> !rsp_valid_q
  );

endmodule

`default_nettype wire

// File: design/wb_width_master.sv
`default_nettype none

module wb_width_master import wb_master_pkg::*;
(
  input  logic         CLK_I,
  input  logic         RST_I,

  // user request
  input  logic         req_valid_i,
  output logic         req_ready_o,
  input  logic         req_we_i,
  input  adr_t         req_adr_i,
  input  master_word_t req_dat_i,

  // read response
  output logic         rsp_valid_o,
  input  logic         rsp_ready_i,
  output master_word_t rsp_dat_o,

  // wishbone classic master
  output logic         wb_cyc_o,
  output logic         wb_stb_o,
  output logic         wb_we_o,
  output adr_t         wb_adr_o,
  output slave_word_t  wb_dat_o,
  input  slave_word_t  wb_dat_i,
  input  logic         wb_ack_i
);

  logic xfer_active;
  logic rsp_pending;

  wb_beat_if u_beat ();

  wb_beat_seq u_seq (
    .CLK_I         (CLK_I),
    .RST_I         (RST_I),
    .req_valid_i   (req_valid_i),
    .req_we_i      (req_we_i),
    .req_adr_i     (req_adr_i),
    .req_dat_i     (req_dat_i),
    .req_ready_o   (req_ready_o),
    .rsp_pending_i (rsp_pending),
    .xfer_active_o (xfer_active),
    .beat          (u_beat.seq)
  );

  wb_bus_port u_port (
    .CLK_I         (CLK_I),
    .RST_I         (RST_I),
    .xfer_active_i (xfer_active),
    .beat          (u_beat.port),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_o      (wb_dat_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i)
  );

  wb_read_gather u_gather (
    .CLK_I         (CLK_I),
    .RST_I         (RST_I),
    .beat          (u_beat.gather),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_dat_o     (rsp_dat_o),
    .rsp_pending_o (rsp_pending)
  );

endmodule

`default_nettype wire

// File: test/wb_slave_model.sv
`default_nettype none

module wb_slave_model import wb_master_pkg::*;
(
  input  logic        CLK_I,
  input  logic        RST_I,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  adr_t        wb_adr_i,
  input  slave_word_t wb_dat_i,
  output slave_word_t wb_dat_o,
  output logic        wb_ack_o
);

  slave_word_t mem [2**ADR_W];
  slave_word_t rdat_q;
  logic        ack_q;
  logic [1:0]  wait_q;  // wait cycles left before the ack

  // inverted address as fill, so every address bit shows in the data
  initial
  begin
    for (int a = 0; a < 2**ADR_W; a++)
    begin
      mem[adr_t'(a)] = ~slave_word_t'(a);
    end
  end

  always @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      ack_q  <= 1'b0;
      rdat_q <= '0;
      wait_q <= 2'($urandom % 4);
    end
    else if (ack_q)
    begin
      ack_q  <= 1'b0;
      wait_q <= 2'($urandom % 4);  // delay for the next access
    end
    else if (wb_cyc_i && wb_stb_i)
    begin
      if (wait_q == 2'd0)
      begin
        ack_q <= 1'b1;
        if (wb_we_i)
        begin
          mem[wb_adr_i] <= wb_dat_i;
        end
        else
        begin
          rdat_q <= mem[wb_adr_i];  // valid together with the ack
        end
      end
      else
      begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  assign wb_dat_o = rdat_q;
  assign wb_ack_o = ack_q;

endmodule

`default_nettype wire

// File: test/tb_wb_master.sv
`default_nettype none

module tb_wb_master import wb_master_pkg::*; ();

  typedef struct packed {
    logic         we;
    adr_t         adr;
    master_word_t dat;
    master_word_t exp;  // expected read word, unused for writes
  } stim_t;

  logic         clk;
  logic         rst;
  logic         req_valid;
  logic         req_ready;
  logic         req_we;
  adr_t         req_adr;
  master_word_t req_dat;
  logic         rsp_valid;
  logic         rsp_ready;
  master_word_t rsp_dat;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  adr_t         wb_adr;
  slave_word_t  wb_dat_m;
  slave_word_t  wb_dat_s;
  logic         wb_ack;

  stim_t        stim_q [$];
  int           cycles = 0;
  int           cycle_limit = 0;

  // copy of the request currently on the bus
  logic         mon_we;
  adr_t         mon_adr;
  master_word_t mon_dat;
  int           mon_beat = 0;  // acks seen for that request
  adr_t         exp_adr;
  slave_word_t  exp_dat;

  wb_width_master u_dut (
    .CLK_I       (clk),
    .RST_I       (rst),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_we_i    (req_we),
    .req_adr_i   (req_adr),
    .req_dat_i   (req_dat),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_dat_o   (rsp_dat),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_adr_o    (wb_adr),
    .wb_dat_o    (wb_dat_m),
    .wb_dat_i    (wb_dat_s),
    .wb_ack_i    (wb_ack)
  );

  wb_slave_model u_slave (
    .CLK_I    (clk),
    .RST_I    (rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_m),
    .wb_dat_o (wb_dat_s),
    .wb_ack_o (wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input master_word_t got,
                             input master_word_t exp);
    if (got !== exp)
    begin
      stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic void add_entry(input logic we, input adr_t adr,
                                    input master_word_t dat, input master_word_t exp);
    stim_t e;
    e = '{we, adr, dat, exp};
    stim_q.push_back(e);
  endfunction

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if ((cycle_limit > 0) && (cycles >= cycle_limit))
    begin
      stop_on_error($sformatf("timeout, run still busy after %0d cycles", cycles));
    end
  end

  // bus monitor, sampled mid-cycle
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (wb_stb && !wb_cyc)
      begin
        stop_on_error("wb_stb_o is high while wb_cyc_o is low");
      end
      if ((mon_beat > 0) && (mon_beat < BEATS) && !wb_cyc)
      begin
        stop_on_error("wb_cyc_o dropped between the beats of one request");
      end
      if (req_valid && req_ready)  // accepted on the coming edge
      begin
        mon_we   = req_we;
        mon_adr  = req_adr;
        mon_dat  = req_dat;
        mon_beat = 0;
      end
      if (wb_stb && wb_ack)
      begin
        if (mon_beat >= BEATS)
        begin
          stop_on_error("more bus acks than beats in one request");
        end
        exp_adr = mon_adr + adr_t'(mon_beat);  // wraps at the top of the range
        exp_dat = mon_dat[mon_beat*SLAVE_W +: SLAVE_W];
        check_value("wb_adr_o", master_word_t'(wb_adr), master_word_t'(exp_adr));
        check_value("wb_we_o", master_word_t'(wb_we), master_word_t'(mon_we));
        if (mon_we)
        begin
          check_value("wb_dat_o", master_word_t'(wb_dat_m), master_word_t'(exp_dat));
        end
        mon_beat = mon_beat + 1;
      end
    end
  end

  task automatic run_entry(input stim_t e);
    int unsigned stall;
    @(posedge clk);
    req_valid <= 1'b1;
    req_we    <= e.we;
    req_adr   <= e.adr;
    req_dat   <= e.dat;
    @(negedge clk);
    while (!req_ready)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    if (e.we)
    begin
      while (!req_ready)  // ready again marks the end of a write
      begin
        @(negedge clk);
      end
      check_value("write beat count", master_word_t'(mon_beat), master_word_t'(BEATS));
    end
    else
    begin
      while (!rsp_valid)
      begin
        @(negedge clk);
      end
      check_value("read beat count", master_word_t'(mon_beat), master_word_t'(BEATS));
      check_value("rsp_dat_o", rsp_dat, e.exp);
      check_value("req_ready_o", master_word_t'(req_ready), '0);
      stall = $urandom % 4;
      repeat (stall)
      begin
        @(negedge clk);
        check_value("rsp_valid_o", master_word_t'(rsp_valid), master_word_t'(1'b1));
        check_value("rsp_dat_o", rsp_dat, e.exp);
        check_value("req_ready_o", master_word_t'(req_ready), '0);
      end
      @(posedge clk);
      rsp_ready <= 1'b1;
      @(posedge clk);
      rsp_ready <= 1'b0;
      @(negedge clk);
      check_value("rsp_valid_o", master_word_t'(rsp_valid), '0);
      check_value("req_ready_o", master_word_t'(req_ready), master_word_t'(1'b1));
    end
  endtask

  initial
  begin
    void'($urandom(32'h8de3));
    rst       <= 1'b1;
    req_valid <= 1'b0;
    req_we    <= 1'b0;
    req_adr   <= '0;
    req_dat   <= '0;
    rsp_ready <= 1'b0;

    // memory fill is the inverted address
    add_entry(1'b1, 8'h20, 32'h11223344, 32'h0);
    add_entry(1'b0, 8'h20, 32'h0, 32'h11223344);
    add_entry(1'b0, 8'h10, 32'h0, 32'hECEDEEEF);
    add_entry(1'b1, 8'hFE, 32'hA5B6C7D8, 32'h0);  // wraps to 8'h01
    add_entry(1'b0, 8'hFE, 32'h0, 32'hA5B6C7D8);
    add_entry(1'b0, 8'h00, 32'h0, 32'hFCFDA5B6);
    add_entry(1'b0, 8'hFF, 32'h0, 32'hFDA5B6C7);
    add_entry(1'b1, 8'h21, 32'hDEADBEEF, 32'h0);
    add_entry(1'b0, 8'h20, 32'h0, 32'hADBEEF44);
    add_entry(1'b1, 8'h80, 32'h0F1E2D3C, 32'h0);
    add_entry(1'b0, 8'h80, 32'h0, 32'h0F1E2D3C);
    add_entry(1'b0, 8'h7E, 32'h0, 32'h2D3C8081);
    cycle_limit = stim_q.size() * BEATS * 8 + 50;

    repeat (3)
    begin
      @(posedge clk);
    end
    rst <= 1'b0;
    @(negedge clk);
    check_value("wb_cyc_o", master_word_t'(wb_cyc), '0);
    check_value("wb_stb_o", master_word_t'(wb_stb), '0);
    check_value("rsp_valid_o", master_word_t'(rsp_valid), '0);
    check_value("req_ready_o", master_word_t'(req_ready), master_word_t'(1'b1));

    foreach (stim_q[i])
    begin
      run_entry(stim_q[i]);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/wb_master_pkg.sv
design/wb_beat_if.sv
design/wb_beat_seq.sv
design/wb_bus_port.sv
design/wb_read_gather.sv
design/wb_width_master.sv
test/wb_slave_model.sv
test/tb_wb_master.sv

// File: run.sh
#!/bin/sh
# compile with Verilator and run, exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_wb_master -f files.f -o tb_wb_master
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/tb_wb_master
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0
